/* hw/issue_pkg.sv */
// shared widths and types for the dual-issue stage
// commit id 0 is reserved as "none", scoreboard slots are ids 1..7
// issue mask bit 0 is slot a, bit 1 is slot b
package issue_pkg;

    localparam int reg_addr_w  = 5;
    localparam int commit_id_w = 3;
    localparam int sb_slots    = 7;   // usable ids, 0 excluded

    typedef logic [reg_addr_w-1:0]  reg_addr_t;
    typedef logic [commit_id_w-1:0] commit_id_t;

    // one decoded instruction, only what the hazard logic needs
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rd_we;
        logic      is_branch;
        logic      is_jump;
        logic      is_csr;
    } inst_slot_t;                    // 20 bits

    typedef struct packed {
        inst_slot_t b;                // upper half
        inst_slot_t a;                // older instruction
    } inst_pair_t;

    // one lane of the commit path
    typedef struct packed {
        logic       valid;
        commit_id_t id;
    } commit_t;

    typedef logic [1:0] issue_mask_t;

endpackage

/* hw/pair_buffer.sv */
// holds one instruction pair until both slots have issued
// payload has no reset, only the slot valid bits do
// no load while flush_i is high, so a pair is never dropped on the handshake
module pair_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  issue_pkg::inst_pair_t  pair_i,
    input  logic                   pair_valid_i,
    output logic                   pair_ready_o,
    input  logic                   flush_i,
    input  issue_pkg::issue_mask_t issue_mask_i,
    output issue_pkg::inst_pair_t  cur_pair_o
);

    issue_pkg::inst_pair_t pair_q;    // held payload
    logic [1:0]            vld_q;     // per-slot still-to-issue
    logic [1:0]            remain;    // slots left after this cycle
    logic                  load;

    // a slot that issues now is gone at the edge
    assign remain = vld_q & ~issue_mask_i;

    // empty, or emptied by this cycle's issue
    assign pair_ready_o = (remain == 2'b00) && !flush_i;
    assign load         = pair_valid_i && pair_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 2'b00;
        end else if (flush_i) begin
            vld_q <= 2'b00;           // flush wins over everything
        end else if (load) begin
            vld_q <= {pair_i.b.valid, pair_i.a.valid};
        end else begin
            vld_q <= remain;          // retire issued slots
        end
    end

    // payload only moves on accept
    always_ff @(posedge clk) begin
        if (load) begin
            pair_q <= pair_i;
        end
    end

    // present issued slots as invalid
    always_comb begin
        cur_pair_o         = pair_q;
        cur_pair_o.a.valid = vld_q[0];
        cur_pair_o.b.valid = vld_q[1];
    end

    // hdu must only pick slots still held here
    a_issue_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue_mask_i & ~vld_q) == 2'b00
    ) else $error("pair_buffer: issue of a slot that is not held");

endmodule

/* hw/hdu.sv */
// hazard detection and issue decision for one instruction pair
// ids are allocated from registered scoreboard state, a same-cycle commit
// frees an entry for hazard checks only, not for allocation
module hdu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  issue_pkg::inst_pair_t  cur_pair_i,
    input  logic                   irq_i,
    input  issue_pkg::commit_t     commit0_i,
    input  issue_pkg::commit_t     commit1_i,
    output issue_pkg::issue_mask_t issue_mask_o,
    output issue_pkg::commit_id_t  id_a_o,
    output issue_pkg::commit_id_t  id_b_o,
    output logic                   lock_o
);

    localparam int n = issue_pkg::sb_slots;

    // scoreboard, index = commit id
    logic [n:1]            sb_vld_q;
    issue_pkg::reg_addr_t  sb_rd_q [1:n];    // 0 for csr entries without a write

    issue_pkg::inst_slot_t a, b;
    logic [n:1]            live;              // valid and not committing now
    logic                  a_rd_nz, b_rd_nz;
    logic                  a_sb_haz, b_sb_haz;
    logic                  b_dep;             // b needs a's result or order
    logic                  a_ctrl;
    logic                  b_clean;
    logic [issue_pkg::commit_id_w-1:0] free_cnt;
    logic                  can_two;
    issue_pkg::commit_id_t alloc_a, alloc_b;
    issue_pkg::issue_mask_t mask;
    logic                  enter_a, enter_b;

    assign a = cur_pair_i.a;
    assign b = cur_pair_i.b;

    // x0 never counts as a destination
    assign a_rd_nz = a.valid && a.rd_we && (a.rd != '0);
    assign b_rd_nz = b.valid && b.rd_we && (b.rd != '0);

    // commit bypass
    always_comb begin
        for (int i = 1; i <= n; i++) begin
            live[i] = sb_vld_q[i]
                && !(commit0_i.valid && commit0_i.id == issue_pkg::commit_id_t'(i))
                && !(commit1_i.valid && commit1_i.id == issue_pkg::commit_id_t'(i));
        end
    end

    // raw / waw against live entries
    always_comb begin
        a_sb_haz = 1'b0;
        b_sb_haz = 1'b0;
        for (int i = 1; i <= n; i++) begin
            if (live[i]) begin
                if (a.valid && (((a.rs1 != '0) && (a.rs1 == sb_rd_q[i]))
                        || ((a.rs2 != '0) && (a.rs2 == sb_rd_q[i]))
                        || (a_rd_nz && (a.rd == sb_rd_q[i])))) begin
                    a_sb_haz = 1'b1;
                end
                if (b.valid && (((b.rs1 != '0) && (b.rs1 == sb_rd_q[i]))
                        || ((b.rs2 != '0) && (b.rs2 == sb_rd_q[i]))
                        || (b_rd_nz && (b.rd == sb_rd_q[i])))) begin
                    b_sb_haz = 1'b1;
                end
            end
        end
    end

    // intra-pair: b reads/writes a's rd, or two csrs back to back
    assign b_dep = a.valid && ((a_rd_nz && ((b.rs1 == a.rd) || (b.rs2 == a.rd)
                                            || (b_rd_nz && (b.rd == a.rd))))
                               || (a.is_csr && b.is_csr));

    assign a_ctrl  = a.valid && (a.is_branch || a.is_jump);   // serialize
    assign b_clean = b.valid && !b_sb_haz && !b_dep;

    // free slot count, registered view only
    always_comb begin
        free_cnt = '0;
        for (int i = 1; i <= n; i++) begin
            free_cnt = free_cnt + {{(issue_pkg::commit_id_w-1){1'b0}}, !sb_vld_q[i]};
        end
    end
    assign can_two = (free_cnt >= 2);

    // lowest free id
    always_comb begin
        alloc_a = '0;
        for (int i = n; i >= 1; i--) begin
            if (!sb_vld_q[i]) alloc_a = issue_pkg::commit_id_t'(i);
        end
    end

    // next free above alloc_a, wrapping past n back to 1
    always_comb begin
        int idx;
        alloc_b = '0;
        for (int k = n - 1; k >= 1; k--) begin
            idx = ((int'(alloc_a) - 1 + k) % n) + 1;
            if (!sb_vld_q[idx]) alloc_b = issue_pkg::commit_id_t'(idx);
        end
    end

    // priority: capacity/irq, a blocked, a control flow, b check
    always_comb begin
        if (!can_two || irq_i) begin
            mask = 2'b00;
        end else if (a_sb_haz) begin
            mask = a_ctrl ? 2'b00 : {b_clean, 1'b0};   // b may slip past a
        end else if (a_ctrl) begin
            mask = 2'b01;
        end else begin
            mask = {b_clean, 1'b1};
        end
    end

    assign issue_mask_o = mask & {b.valid, a.valid};   // invalid never issues
    assign id_a_o       = issue_mask_o[0] ? alloc_a : '0;
    assign id_b_o       = issue_mask_o[1] ? alloc_b : '0;

    // csr goes in even without a register write
    assign enter_a = issue_mask_o[0] && (a_rd_nz || a.is_csr);
    assign enter_b = issue_mask_o[1] && (b_rd_nz || b.is_csr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sb_vld_q <= '0;
        end else begin
            if (commit0_i.valid && commit0_i.id != '0) sb_vld_q[commit0_i.id] <= 1'b0;
            if (commit1_i.valid && commit1_i.id != '0) sb_vld_q[commit1_i.id] <= 1'b0;
            if (enter_a) sb_vld_q[id_a_o] <= 1'b1;   // allocated ids are never committing
            if (enter_b) sb_vld_q[id_b_o] <= 1'b1;
        end
    end

    // destination payload
    always_ff @(posedge clk) begin
        if (enter_a) sb_rd_q[id_a_o] <= a_rd_nz ? a.rd : '0;
        if (enter_b) sb_rd_q[id_b_o] <= b_rd_nz ? b.rd : '0;
    end

    assign lock_o = |sb_vld_q;

    // pipe must only return ids that were handed out
    a_commit_id_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(commit0_i.valid && commit0_i.id == '0) && !(commit1_i.valid && commit1_i.id == '0)
    ) else $error("hdu: commit with reserved id 0");

endmodule

/* hw/long_exec_pipe.sv */
// fixed-latency stand-in for the multi-cycle units, no back-pressure
// an id issued in cycle t shows up on its lane LATENCY cycles later
module long_exec_pipe #(
    parameter int LATENCY = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  issue_pkg::issue_mask_t issue_mask_i,
    input  issue_pkg::commit_id_t  id_a_i,
    input  issue_pkg::commit_id_t  id_b_i,
    output issue_pkg::commit_t     commit0_o,
    output issue_pkg::commit_t     commit1_o
);

    // stage s, lane 0 = slot a, lane 1 = slot b
    logic [1:0]            vld_q [LATENCY];
    issue_pkg::commit_id_t id_q  [LATENCY][2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < LATENCY; s++) begin
                vld_q[s] <= 2'b00;
            end
        end else begin
            vld_q[0] <= issue_mask_i;            // capture at issue edge
            for (int s = 1; s < LATENCY; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    // ids follow the valids, no reset needed
    always_ff @(posedge clk) begin
        id_q[0][0] <= id_a_i;
        id_q[0][1] <= id_b_i;
        for (int s = 1; s < LATENCY; s++) begin
            id_q[s][0] <= id_q[s-1][0];
            id_q[s][1] <= id_q[s-1][1];
        end
    end

    // last stage is the commit
    assign commit0_o.valid = vld_q[LATENCY-1][0];
    assign commit0_o.id    = id_q[LATENCY-1][0];
    assign commit1_o.valid = vld_q[LATENCY-1][1];
    assign commit1_o.id    = id_q[LATENCY-1][1];

    // single-cycle units would bypass this pipe entirely
    a_latency_min: assert property (
        @(posedge clk) disable iff (!rst_n) LATENCY >= 2
    ) else $error("long_exec_pipe: LATENCY below 2");

endmodule

/* hw/issue_top.sv */
// dual-issue stage: pair buffer, hazard unit, long-latency pipe
// LATENCY sets the commit delay of every issued instruction
module issue_top #(
    parameter int LATENCY = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  issue_pkg::inst_pair_t  pair_i,
    input  logic                   pair_valid_i,
    output logic                   pair_ready_o,
    input  logic                   flush_i,
    input  logic                   irq_i,
    output issue_pkg::issue_mask_t issue_o,
    output issue_pkg::commit_id_t  id_a_o,
    output issue_pkg::commit_id_t  id_b_o,
    output issue_pkg::commit_t     commit0_o,
    output issue_pkg::commit_t     commit1_o,
    output logic                   lock_o
);

    issue_pkg::inst_pair_t cur_pair;   // buffer to hdu
    issue_pkg::commit_t    c0, c1;     // commit lanes, fed back

    pair_buffer u_buf (
        .clk, .rst_n,
        .pair_i, .pair_valid_i, .pair_ready_o, .flush_i,
        .issue_mask_i (issue_o),
        .cur_pair_o   (cur_pair)
    );

    hdu u_hdu (
        .clk, .rst_n,
        .cur_pair_i (cur_pair), .irq_i,
        .commit0_i  (c0), .commit1_i (c1),
        .issue_mask_o (issue_o), .id_a_o, .id_b_o, .lock_o
    );

    long_exec_pipe #(.LATENCY(LATENCY)) u_pipe (
        .clk, .rst_n,
        .issue_mask_i (issue_o), .id_a_i (id_a_o), .id_b_i (id_b_o),
        .commit0_o    (c0), .commit1_o (c1)
    );

    assign commit0_o = c0;
    assign commit1_o = c1;

endmodule

/* tests/tb_issue_top.sv */
// table-driven testbench for issue_top with LATENCY 4
// every row starts from an empty scoreboard, so the preload gets ids 1, 2 and the probe 3, 4
// commit checks follow the issued ids, shifted by LATENCY cycles
module tb_issue_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 4;
    localparam int n_hand  = 10;
    localparam int n_rows  = n_hand + 3;                    // random filler rows at the end
    localparam int limit   = n_rows * (LATENCY + 6) + 50;   // watchdog, in cycles

    logic clk, rst_n, pair_valid_i, pair_ready_o, flush_i, irq_i, lock_o;
    issue_pkg::inst_pair_t  pair_i;
    issue_pkg::issue_mask_t issue_o;
    issue_pkg::commit_id_t  id_a_o, id_b_o;
    issue_pkg::commit_t     commit0_o, commit1_o;

    issue_pkg::inst_pair_t  pre_tab [n_rows];
    issue_pkg::inst_pair_t  probe_tab [n_rows];
    logic                   irq_tab [n_rows];
    issue_pkg::issue_mask_t mask_tab [n_rows];
    issue_pkg::commit_t     exp_c0 [512];   // expected lane 0 commit, by cycle
    issue_pkg::commit_t     exp_c1 [512];
    int cyc, mask_errs, id_errs, commit_errs, bit_errs;

    issue_top #(.LATENCY(LATENCY)) uut (
        .clk, .rst_n, .pair_i, .pair_valid_i, .pair_ready_o, .flush_i, .irq_i,
        .issue_o, .id_a_o, .id_b_o, .commit0_o, .commit1_o, .lock_o
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        repeat (limit) @(posedge clk);
        $display("watchdog: simulation ran past %0d cycles without finishing", limit);
        $display("Checks failed");
        $finish;
    end

    // kind is {branch, jump, csr}
    function automatic issue_pkg::inst_slot_t mk_slot(input int rd, rs1, rs2,
            input logic we, input logic [2:0] kind);
        return issue_pkg::inst_slot_t'({1'b1, 5'(rd), 5'(rs1), 5'(rs2), we, kind});
    endfunction

    task automatic check_mask(input issue_pkg::issue_mask_t got, exp, input string what);
        if (got !== exp) begin
            mask_errs++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input issue_pkg::commit_id_t got, exp, input string what);
        if (got !== exp) begin
            id_errs++;
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // id of an idle lane is don't care
    task automatic check_commit(input issue_pkg::commit_t got, exp, input string what);
        if (got.valid !== exp.valid || (exp.valid && got.id !== exp.id)) begin
            commit_errs++;
            $display("ERROR %0t: %s got %b/%0d expected %b/%0d", $time, what,
                     got.valid, got.id, exp.valid, exp.id);
        end
    endtask

    task automatic check_bit(input logic got, exp, input string what);
        if (got !== exp) begin
            bit_errs++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // sample mid-cycle, then step to 10 ns past the next rising edge
    task automatic cycle_check(input issue_pkg::issue_mask_t m,
            input issue_pkg::commit_id_t ia, ib, input logic rdy);
        @(negedge clk);
        check_mask(issue_o, m, "issue_o");
        check_id(id_a_o, ia, "id_a_o");
        check_id(id_b_o, ib, "id_b_o");
        check_bit(pair_ready_o, rdy, "pair_ready_o");
        check_commit(commit0_o, exp_c0[cyc], "commit0_o");
        check_commit(commit1_o, exp_c1[cyc], "commit1_o");
        exp_c0[cyc + LATENCY] = {m[0], ia};   // slot a returns on lane 0
        exp_c1[cyc + LATENCY] = {m[1], ib};
        cyc++;
        @(posedge clk);
        #10;
    endtask

    task automatic set_row(input int r, input issue_pkg::inst_slot_t pa, pb,
            input logic irq, input issue_pkg::issue_mask_t m);
        pre_tab[r]   = {mk_slot(6, 3, 4, 1, 0), mk_slot(5, 1, 2, 1, 0)};   // x5, x6 live
        probe_tab[r] = {pb, pa};
        irq_tab[r]   = irq;
        mask_tab[r]  = m;
    endtask

    task automatic drain;
        repeat (LATENCY + 2) cycle_check(2'b00, 0, 0, 1'b1);
        check_bit(lock_o, 1'b0, "lock_o after drain");
    endtask

    task automatic run_row(input int r);
        pair_i       = pre_tab[r];
        pair_valid_i = 1'b1;
        cycle_check(2'b00, 0, 0, 1'b1);           // empty machine accepts the preload
        pair_i = probe_tab[r];
        cycle_check(2'b11, 1, 2, 1'b1);           // preload issues, probe accepted
        pair_valid_i = 1'b0;
        flush_i      = 1'b1;                       // leftover of the probe is dropped
        irq_i        = irq_tab[r];
        check_bit(lock_o, 1'b1, "lock_o with preload live");
        cycle_check(mask_tab[r], mask_tab[r][0] ? 3 : 0, mask_tab[r][1] ? 4 : 0, 1'b0);
        flush_i = 1'b0;
        irq_i   = 1'b0;
        drain();
    endtask

    initial begin
        void'($urandom(95812));
        rst_n        = 1'b0;
        pair_i       = '0;
        pair_valid_i = 1'b0;
        flush_i      = 1'b0;
        irq_i        = 1'b0;
        {cyc, mask_errs, id_errs, commit_errs, bit_errs} = '0;
        foreach (exp_c0[i]) begin
            exp_c0[i] = '0;
            exp_c1[i] = '0;
        end
        set_row(0, mk_slot(7, 8, 9, 1, 0), mk_slot(10, 11, 12, 1, 0), 0, 2'b11);
        set_row(1, mk_slot(7, 5, 9, 1, 0), mk_slot(10, 11, 12, 1, 0), 0, 2'b10); // raw, b slips
        set_row(2, mk_slot(6, 8, 9, 1, 0), mk_slot(10, 5, 12, 1, 0), 0, 2'b00);  // waw + raw
        set_row(3, mk_slot(7, 5, 9, 1, 0), mk_slot(10, 7, 12, 1, 0), 0, 2'b00);  // b needs a
        set_row(4, mk_slot(7, 8, 9, 1, 0), mk_slot(10, 11, 7, 1, 0), 0, 2'b01);  // raw in pair
        set_row(5, mk_slot(0, 0, 0, 1, 0), mk_slot(0, 0, 0, 1, 0), 0, 2'b11);    // x0 only
        set_row(6, mk_slot(7, 8, 9, 1, 3'b001), mk_slot(10, 11, 12, 1, 3'b001), 0, 2'b01);
        set_row(7, mk_slot(0, 8, 9, 0, 3'b100), mk_slot(10, 11, 12, 1, 0), 0, 2'b01); // branch
        set_row(8, mk_slot(1, 6, 0, 1, 3'b010), mk_slot(10, 11, 12, 1, 0), 0, 2'b00); // jalr raw
        set_row(9, mk_slot(7, 8, 9, 1, 0), mk_slot(10, 11, 12, 1, 0), 1, 2'b00);      // irq
        for (int r = n_hand; r < n_rows; r++) begin   // a in x10..x20, b in x21..x31
            set_row(r, mk_slot(10 + $urandom % 11, 10 + $urandom % 11, 10 + $urandom % 11, 1, 0),
                    mk_slot(21 + $urandom % 11, 21 + $urandom % 11, 21 + $urandom % 11, 1, 0),
                    0, 2'b11);
        end
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) run_row(r);

        // capacity, three pairs take six ids and the fourth waits for the first commit
        pair_valid_i = 1'b1;
        for (int k = 0; k < 4; k++) begin
            pair_i = {mk_slot(12 + 2 * k, 0, 0, 1, 0),
                      mk_slot(11 + 2 * k, (k == 3) ? 13 : 0, 0, 1, 0)};   // last one reads x13
            if (k == 0) cycle_check(2'b00, 0, 0, 1'b1);
            else cycle_check(2'b11, 3'(2 * k - 1), 3'(2 * k), 1'b1);
        end
        pair_valid_i = 1'b0;
        cycle_check(2'b00, 0, 0, 1'b0);   // one id free
        cycle_check(2'b00, 0, 0, 1'b0);   // ids 1, 2 commit, count is registered
        cycle_check(2'b11, 1, 2, 1'b1);   // x13 commits in this cycle, bypassed
        drain();

        // flush of a half-issued pair, b waits on the jal result
        pair_i       = {mk_slot(2, 1, 0, 1, 0), mk_slot(1, 0, 0, 1, 3'b010)};
        pair_valid_i = 1'b1;
        cycle_check(2'b00, 0, 0, 1'b1);
        pair_valid_i = 1'b0;
        cycle_check(2'b01, 1, 0, 1'b0);   // jal alone
        pair_i       = {mk_slot(21, 0, 0, 1, 0), mk_slot(20, 0, 0, 1, 0)};
        pair_valid_i = 1'b1;
        flush_i      = 1'b1;
        cycle_check(2'b00, 0, 0, 1'b0);   // b blocked, dropped at the edge
        flush_i = 1'b0;
        cycle_check(2'b00, 0, 0, 1'b1);   // empty again, next pair accepted
        pair_valid_i = 1'b0;
        cycle_check(2'b11, 2, 3, 1'b1);   // id 1 still live
        drain();

        $display("errors: mask %0d, id %0d, commit %0d, bit %0d",
                 mask_errs, id_errs, commit_errs, bit_errs);
        if (mask_errs + id_errs + commit_errs + bit_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/issue_pkg.sv
hw/pair_buffer.sv
hw/hdu.sv
hw/long_exec_pipe.sv
hw/issue_top.sv
tests/tb_issue_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_issue_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
